// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_err_inject_top
FILELIST  ?= err_inject_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: block_lock.sv
`timescale 1ns/100ps
`default_nettype none

`include "err_inject_consts.svh"

// Sync header lock in the manner of clause 49, plus a bad header counter
module block_lock
        import pcs_block_pkg::*;
(
        input  wire                     i_clock,
        input  wire                     i_reset,
        input  wire                     i_valid,
        input  wire sync_header_t       i_sync_header,
        output logic                    o_block_lock,
        output logic [15:0]             o_sh_err_count
);

        localparam int LOCK_WINDOW = 64;
        localparam int NB_GOOD     = $clog2(`LOCK_GOOD_COUNT);
        localparam int NB_WIN      = $clog2(LOCK_WINDOW);
        localparam int NB_BAD      = $clog2(`LOCK_BAD_LIMIT);

        logic [NB_GOOD-1:0]     good_cnt;       // Consecutive clean headers while unlocked
        logic [NB_WIN-1:0]      win_cnt;
        logic [NB_BAD-1:0]      bad_cnt;        // Bad headers in current window
        logic                   sh_ok;

        assign sh_ok = (i_sync_header == SH_DATA) || (i_sync_header == SH_CTRL);

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        o_block_lock <= 1'b0;
                        good_cnt     <= '0;
                        win_cnt      <= '0;
                        bad_cnt      <= '0;
                end
                else if (i_valid && !o_block_lock)
                begin
                        if (!sh_ok)
                                good_cnt <= '0;
                        else if (good_cnt == NB_GOOD'(`LOCK_GOOD_COUNT - 1))
                        begin
                                o_block_lock <= 1'b1;
                                good_cnt     <= '0;
                                win_cnt      <= '0;     // First window opens at lock
                                bad_cnt      <= '0;
                        end
                        else
                                good_cnt <= good_cnt + 1'b1;
                end
                else if (i_valid)
                begin
                        if (!sh_ok && bad_cnt == NB_BAD'(`LOCK_BAD_LIMIT - 1))
                        begin
                                o_block_lock <= 1'b0;
                                win_cnt      <= '0;
                                bad_cnt      <= '0;
                        end
                        else if (win_cnt == NB_WIN'(LOCK_WINDOW - 1))
                        begin
                                win_cnt <= '0;
                                bad_cnt <= '0;
                        end
                        else
                        begin
                                win_cnt <= win_cnt + 1'b1;
                                if (!sh_ok)
                                        bad_cnt <= bad_cnt + 1'b1;
                        end
                end
        end

        // Saturating count of every invalid header
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                        o_sh_err_count <= '0;
                else if (i_valid && !sh_ok && o_sh_err_count != '1)
                        o_sh_err_count <= o_sh_err_count + 1'b1;
        end

        a_count_monotonic: assert property (
                @(posedge i_clock) disable iff (i_reset)
                !$past(i_reset) |-> (o_sh_err_count >= $past(o_sh_err_count))
        ) else $error("%t block_lock: o_sh_err_count went down", $time);

endmodule

`default_nettype wire

// File: err_cfg_if.sv
`timescale 1ns/100ps
`default_nettype none

// Error pattern configuration, sampled by the sink only while update is high
interface err_cfg_if
        import err_cfg_pkg::*;
        ();

        err_mode_t      mode;
        burst_cnt_t     burst;           // Blocks to corrupt per period
        period_cnt_t    period;          // Valid blocks per period
        repeat_cnt_t    repeats;         // Number of corrupted periods
        logic           update;          // Single-cycle load strobe

        modport source
        (
                output mode,
                output burst,
                output period,
                output repeats,
                output update
        );

        modport sink
        (
                input  mode,
                input  burst,
                input  period,
                input  repeats,
                input  update
        );

endinterface

`default_nettype wire

// File: err_cfg_pkg.sv
`default_nettype none

`include "err_inject_consts.svh"

package err_cfg_pkg;

        // One-hot selection of blocks eligible for corruption
        typedef enum logic [3:0] {
                MODE_ALIGN = 4'b0001,
                MODE_CTRL  = 4'b0010,
                MODE_DATA  = 4'b0100,
                MODE_ALL   = 4'b1000
        } err_mode_t;

        localparam int NB_BURST_CNT  = $clog2(`MAX_ERR_BURST);
        localparam int NB_PERIOD_CNT = $clog2(`MAX_ERR_PERIOD);
        localparam int NB_REPEAT_CNT = $clog2(`MAX_ERR_REPEAT);

        typedef logic [NB_BURST_CNT-1:0]  burst_cnt_t;
        typedef logic [NB_PERIOD_CNT-1:0] period_cnt_t;
        typedef logic [NB_REPEAT_CNT-1:0] repeat_cnt_t;

endpackage

`default_nettype wire

// File: err_inject_consts.svh
`ifndef ERR_INJECT_CONSTS_SVH
`define ERR_INJECT_CONSTS_SVH

// Coded block width, sync header plus payload
`define NB_CODED_BLOCK 66

// Error pattern limits
`define MAX_ERR_BURST 1024
`define MAX_ERR_PERIOD 1024
`define MAX_ERR_REPEAT 15

// LFSR for the invalid header choice
`define PRBS_SEED 12354
`define PRBS_TAP 9

// Block lock thresholds
`define LOCK_GOOD_COUNT 64       // Clean headers needed to lock
`define LOCK_BAD_LIMIT 16        // Bad headers per window to unlock

`endif

// File: err_inject_top.f
+incdir+.
pcs_block_pkg.sv
err_cfg_pkg.sv
err_cfg_if.sv
prbs.sv
sh_breaker.sv
block_lock.sv
err_inject_top.sv
tb_err_inject_top.sv

// File: err_inject_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "err_inject_consts.svh"

module err_inject_top
        import pcs_block_pkg::*, err_cfg_pkg::*;
(
        input  wire                             i_clock,
        input  wire                             i_reset,
        input  wire                             i_valid,
        input  wire [`NB_CODED_BLOCK-1:0]       i_data,
        input  wire                             i_aligner_tag,
        input  wire [3:0]                       i_rf_mode,
        input  wire                             i_rf_update,
        input  wire burst_cnt_t                 i_rf_error_burst,
        input  wire period_cnt_t                i_rf_error_period,
        input  wire repeat_cnt_t                i_rf_error_repeat,
        output logic                            o_valid,
        output logic [`NB_CODED_BLOCK-1:0]      o_data,
        output logic                            o_aligner_tag,
        output logic                            o_block_lock,
        output logic [15:0]                     o_sh_err_count
);

        err_cfg_if      cfg_bus ();
        coded_block_t   blk_out;
        logic           valid_out;

        assign cfg_bus.mode    = err_mode_t'(i_rf_mode);
        assign cfg_bus.burst   = i_rf_error_burst;
        assign cfg_bus.period  = i_rf_error_period;
        assign cfg_bus.repeats = i_rf_error_repeat;
        assign cfg_bus.update  = i_rf_update;

        assign o_valid = valid_out;
        assign o_data  = blk_out;

        sh_breaker u_sh_breaker
        (
                .i_clock        (i_clock),
                .i_reset        (i_reset),
                .i_valid        (i_valid),
                .i_data         (i_data),
                .i_aligner_tag  (i_aligner_tag),
                .cfg            (cfg_bus),
                .o_valid        (valid_out),
                .o_data         (blk_out),
                .o_aligner_tag  (o_aligner_tag)
        );

        // Checker sees the stream after corruption
        block_lock u_block_lock
        (
                .i_clock        (i_clock),
                .i_reset        (i_reset),
                .i_valid        (valid_out),
                .i_sync_header  (blk_out.sh),
                .o_block_lock   (o_block_lock),
                .o_sh_err_count (o_sh_err_count)
        );

endmodule

`default_nettype wire

// File: pcs_block_pkg.sv
`default_nettype none

`include "err_inject_consts.svh"

package pcs_block_pkg;

        localparam int NB_SH      = 2;
        localparam int NB_PAYLOAD = `NB_CODED_BLOCK - NB_SH;

        typedef logic [NB_SH-1:0] sync_header_t;

        // Valid header codes, 00 and 11 are invalid
        localparam sync_header_t SH_DATA = 2'b01;
        localparam sync_header_t SH_CTRL = 2'b10;

        // Header sits in the top two bits
        typedef struct packed {
                sync_header_t            sh;
                logic [NB_PAYLOAD-1:0]   payload;
        } coded_block_t;

endpackage

`default_nettype wire

// File: prbs.sv
`timescale 1ns/100ps
`default_nettype none

`include "err_inject_consts.svh"

// Fibonacci LFSR, one new bit per enabled cycle
module prbs
#(
        parameter int N_BITS = 11,
        parameter int SEED   = `PRBS_SEED
)
(
        input  wire     i_clock,
        input  wire     i_reset,
        input  wire     i_enable,
        output logic    o_bit
);

        // Only the low N_BITS of the seed are loaded
        localparam logic [N_BITS-1:0] SEED_VEC = SEED[N_BITS-1:0];

        logic [N_BITS-1:0]      lfsr;
        logic                   feedback;

        assign feedback = lfsr[N_BITS-1] ^ lfsr[`PRBS_TAP-1];
        assign o_bit    = lfsr[N_BITS-1];

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                        lfsr <= SEED_VEC;
                else if (i_enable)
                        lfsr <= {lfsr[N_BITS-2:0], feedback};   // Shift toward the MSB
        end

        // All zeros would lock the LFSR up for good
        a_lfsr_nonzero: assert property (
                @(posedge i_clock) disable iff (i_reset)
                lfsr != '0
        ) else $error("%t prbs: lfsr reached all zeros", $time);

endmodule

`default_nettype wire

// File: sh_breaker.sv
`timescale 1ns/100ps
`default_nettype none

// Replaces the sync header of selected blocks with 00 or 11, payload untouched
module sh_breaker
        import pcs_block_pkg::*, err_cfg_pkg::*;
(
        input  wire                     i_clock,
        input  wire                     i_reset,
        input  wire                     i_valid,
        input  wire coded_block_t       i_data,
        input  wire                     i_aligner_tag,
        err_cfg_if.sink                 cfg,
        output logic                    o_valid,
        output coded_block_t            o_data,
        output logic                    o_aligner_tag
);

        err_mode_t      mode;
        burst_cnt_t     burst_cfg;      // Kept for the reload at each period
        period_cnt_t    period_cfg;
        burst_cnt_t     burst_cnt;      // Blocks still to corrupt in this period
        period_cnt_t    period_cnt;     // Position inside the period
        repeat_cnt_t    repeat_cnt;     // Periods still to corrupt

        logic           eligible;
        logic           corrupt;
        logic           period_end;
        logic           prbs_bit;
        sync_header_t   err_sh;

        always_comb
        begin
                case (mode)
                MODE_ALIGN: eligible = i_aligner_tag;
                MODE_CTRL:  eligible = (i_data.sh == SH_CTRL);
                MODE_DATA:  eligible = (i_data.sh == SH_DATA);
                MODE_ALL:   eligible = 1'b1;
                default:    eligible = 1'b0;
                endcase
        end

        assign corrupt    = i_valid && eligible && (burst_cnt != '0) &&
                            (repeat_cnt != '0) && !cfg.update;
        assign period_end = (period_cnt == period_cnt_t'(period_cfg - 1'b1));  // 0 means full range
        assign err_sh     = prbs_bit ? 2'b11 : 2'b00;

        always_comb
        begin
                o_valid       = i_valid;
                o_aligner_tag = i_aligner_tag;
                o_data        = i_data;
                if (corrupt)
                        o_data.sh = err_sh;
        end

        // Configuration registers
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        mode       <= MODE_ALL;
                        burst_cfg  <= '0;
                        period_cfg <= '0;
                end
                else if (cfg.update)
                begin
                        mode       <= cfg.mode;
                        burst_cfg  <= cfg.burst;
                        period_cfg <= cfg.period;
                end
        end

        // Burst, period and repeat counters
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        burst_cnt  <= '0;
                        period_cnt <= '0;
                        repeat_cnt <= '0;
                end
                else if (cfg.update)
                begin
                        burst_cnt  <= cfg.burst;
                        period_cnt <= '0;               // Next valid block opens a period
                        repeat_cnt <= cfg.repeats;
                end
                else if (i_valid)
                begin
                        if (period_end)
                        begin
                                period_cnt <= '0;
                                burst_cnt  <= burst_cfg;
                                if (repeat_cnt != '0)
                                        repeat_cnt <= repeat_cnt - 1'b1;
                        end
                        else
                        begin
                                period_cnt <= period_cnt + 1'b1;
                                if (corrupt)
                                        burst_cnt <= burst_cnt - 1'b1;
                        end
                end
        end

        // New header choice on every valid block
        prbs u_prbs
        (
                .i_clock        (i_clock),
                .i_reset        (i_reset),
                .i_enable       (i_valid),
                .o_bit          (prbs_bit)
        );

        a_mode_onehot: assert property (
                @(posedge i_clock) disable iff (i_reset)
                $onehot(mode)
        ) else $error("%t sh_breaker: mode %b not one-hot", $time, mode);

        a_corrupt_shape: assert property (
                @(posedge i_clock) disable iff (i_reset)
                (o_valid && (o_data.sh != i_data.sh)) |->
                        ((o_data.sh == 2'b00 || o_data.sh == 2'b11) &&
                         (o_data.payload == i_data.payload))
        ) else $error("%t sh_breaker: bad corrupted block %h", $time, o_data);

endmodule

`default_nettype wire

// File: tb_err_inject_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "err_inject_consts.svh"

module tb_err_inject_top
        import pcs_block_pkg::*, err_cfg_pkg::*;
();

        localparam int N_LOCK_VALID  = 64 + 1 + 63 + 70;        // Lock then a burst of 16 then relock
        localparam int N_BURST_VALID = 1 + 40;
        localparam int N_MODE_VALID  = 1 + (1 + 40) + (1 + 40) + (1 + 60);
        localparam int N_VALID       = N_LOCK_VALID + N_BURST_VALID + N_MODE_VALID;
        localparam int STIM_CYCLES   = (N_VALID * 4) / 3 + 3 + 3;       // 1-in-4 gaps
        localparam int TIMEOUT       = 2 * STIM_CYCLES;

        logic                           i_clock;
        logic                           i_reset;
        logic                           i_valid;
        logic [`NB_CODED_BLOCK-1:0]     i_data;
        logic                           i_aligner_tag;
        logic [3:0]                     i_rf_mode;
        logic                           i_rf_update;
        burst_cnt_t                     i_rf_error_burst;
        period_cnt_t                    i_rf_error_period;
        repeat_cnt_t                    i_rf_error_repeat;
        logic                           o_valid;
        logic [`NB_CODED_BLOCK-1:0]     o_data;
        logic                           o_aligner_tag;
        logic                           o_block_lock;
        logic [15:0]                    o_sh_err_count;

        coded_block_t   in_blk;
        coded_block_t   out_blk;
        logic [31:0]    rng;
        int             mismatches;
        int             other_errors;
        int             cycle_count;

        // Reference model state
        err_mode_t      m_mode;
        int             m_burst_len;
        int             m_period_len;
        int             m_burst_left;
        int             m_pos;
        int             m_repeat_left;
        logic           m_corrupt;
        logic [15:0]    exp_err_count;
        logic           exp_lock;
        int             good_run;
        int             win_pos;
        int             bad_in_win;
        logic           lock_q;
        int             lock_rises;
        int             lock_drops;
        int             count_before;

        assign in_blk  = i_data;
        assign out_blk = o_data;

        err_inject_top uut
        (
                .i_clock                (i_clock),
                .i_reset                (i_reset),
                .i_valid                (i_valid),
                .i_data                 (i_data),
                .i_aligner_tag          (i_aligner_tag),
                .i_rf_mode              (i_rf_mode),
                .i_rf_update            (i_rf_update),
                .i_rf_error_burst       (i_rf_error_burst),
                .i_rf_error_period      (i_rf_error_period),
                .i_rf_error_repeat      (i_rf_error_repeat),
                .o_valid                (o_valid),
                .o_data                 (o_data),
                .o_aligner_tag          (o_aligner_tag),
                .o_block_lock           (o_block_lock),
                .o_sh_err_count         (o_sh_err_count)
        );

        initial
        begin
                i_clock = 1'b0;
                forever #4 i_clock = ~i_clock;
        end

        function automatic logic [31:0] lcg_step(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        function automatic logic block_selected(input err_mode_t mode, input coded_block_t blk,
                                                input logic tag);
                case (mode)
                MODE_ALIGN: return tag;
                MODE_CTRL:  return blk.sh == SH_CTRL;
                MODE_DATA:  return blk.sh == SH_DATA;
                MODE_ALL:   return 1'b1;
                default:    return 1'b0;
                endcase
        endfunction

        // One clock of stimulus with a fresh random block
        task automatic drive_cycle(input logic want_valid, input logic upd);
                coded_block_t   blk;
                logic [31:0]    r;
                rng = lcg_step(rng);
                blk.payload[63:32] = rng;
                rng = lcg_step(rng);
                blk.payload[31:0] = rng;
                rng = lcg_step(rng);
                r = rng;
                blk.sh = r[31] ? SH_CTRL : SH_DATA;
                @(posedge i_clock);
                i_valid       <= want_valid;
                i_data        <= blk;
                i_aligner_tag <= (r[30:28] == 3'b000);  // About one in eight
                i_rf_update   <= upd;
        endtask

        task automatic send_valid(input int n);
                int sent;
                sent = 0;
                while (sent < n)
                begin
                        rng = lcg_step(rng);
                        if (rng[29:28] == 2'b00)
                                drive_cycle(1'b0, 1'b0);        // Gap
                        else
                        begin
                                drive_cycle(1'b1, 1'b0);
                                sent++;
                        end
                end
        endtask

        // Update strobe rides on a valid block
        task automatic load_config(input err_mode_t mode, input int burst, input int period,
                                   input int repeats);
                drive_cycle(1'b1, 1'b1);
                i_rf_mode         <= mode;
                i_rf_error_burst  <= burst_cnt_t'(burst);
                i_rf_error_period <= period_cnt_t'(period);
                i_rf_error_repeat <= repeat_cnt_t'(repeats);
        endtask

        assign m_corrupt = i_valid && !i_rf_update && m_burst_left != 0 && m_repeat_left != 0 &&
                           block_selected(m_mode, in_blk, i_aligner_tag);

        always @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        m_mode        <= MODE_ALL;
                        m_burst_len   <= 0;
                        m_period_len  <= `MAX_ERR_PERIOD;
                        m_burst_left  <= 0;
                        m_pos         <= 0;
                        m_repeat_left <= 0;
                        exp_err_count <= '0;
                end
                else
                begin
                        if (m_corrupt && exp_err_count != 16'hffff)
                                exp_err_count <= exp_err_count + 16'd1;
                        if (i_rf_update)
                        begin
                                m_mode        <= err_mode_t'(i_rf_mode);
                                m_burst_len   <= int'(i_rf_error_burst);
                                m_burst_left  <= int'(i_rf_error_burst);
                                m_period_len  <= (i_rf_error_period == '0) ?
                                                 `MAX_ERR_PERIOD : int'(i_rf_error_period);
                                m_repeat_left <= int'(i_rf_error_repeat);
                                m_pos         <= 0;
                        end
                        else if (i_valid)
                        begin
                                if (m_pos == m_period_len - 1)
                                begin
                                        m_pos        <= 0;
                                        m_burst_left <= m_burst_len;
                                        if (m_repeat_left > 0)
                                                m_repeat_left <= m_repeat_left - 1;
                                end
                                else
                                begin
                                        m_pos <= m_pos + 1;
                                        if (m_corrupt)
                                                m_burst_left <= m_burst_left - 1;
                                end
                        end
                end
        end

        // Expected lock state with bad headers only on corrupted blocks
        always @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        exp_lock   <= 1'b0;
                        good_run   <= 0;
                        win_pos    <= 0;
                        bad_in_win <= 0;
                end
                else if (i_valid && !exp_lock)
                begin
                        if (m_corrupt)
                                good_run <= 0;
                        else if (good_run + 1 == `LOCK_GOOD_COUNT)
                        begin
                                exp_lock   <= 1'b1;
                                good_run   <= 0;
                                win_pos    <= 0;
                                bad_in_win <= 0;
                        end
                        else
                                good_run <= good_run + 1;
                end
                else if (i_valid)
                begin
                        if (m_corrupt && bad_in_win + 1 == `LOCK_BAD_LIMIT)
                                exp_lock <= 1'b0;
                        else if (win_pos + 1 == 64)
                        begin
                                win_pos    <= 0;
                                bad_in_win <= 0;
                        end
                        else
                        begin
                                win_pos <= win_pos + 1;
                                if (m_corrupt)
                                        bad_in_win <= bad_in_win + 1;
                        end
                end
        end

        always @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        lock_q     <= 1'b0;
                        lock_rises <= 0;
                        lock_drops <= 0;
                end
                else
                begin
                        lock_q <= o_block_lock;
                        if (o_block_lock && !lock_q)
                                lock_rises <= lock_rises + 1;
                        if (!o_block_lock && lock_q)
                                lock_drops <= lock_drops + 1;
                end
        end

        a_pass_through: assert property (@(posedge i_clock) disable iff (i_reset)
                !m_corrupt |-> (o_data == i_data))
        else
        begin
                mismatches++;
                $display("mismatch at %0t: o_data got %h expected %h", $time,
                         $sampled(o_data), $sampled(i_data));
        end

        a_bad_header: assert property (@(posedge i_clock) disable iff (i_reset)
                m_corrupt |-> (out_blk.sh == 2'b00 || out_blk.sh == 2'b11))
        else
        begin
                mismatches++;
                $display("mismatch at %0t: o_data header got %b expected 00 or 11", $time,
                         $sampled(out_blk.sh));
        end

        a_payload_kept: assert property (@(posedge i_clock) disable iff (i_reset)
                m_corrupt |-> (out_blk.payload == in_blk.payload))
        else
        begin
                mismatches++;
                $display("mismatch at %0t: o_data payload got %h expected %h", $time,
                         $sampled(out_blk.payload), $sampled(in_blk.payload));
        end

        a_valid_tag: assert property (@(posedge i_clock) disable iff (i_reset)
                (o_valid == i_valid) && (o_aligner_tag == i_aligner_tag))
        else
        begin
                mismatches++;
                $display("mismatch at %0t: o_valid/o_aligner_tag got %b%b expected %b%b", $time,
                         $sampled(o_valid), $sampled(o_aligner_tag),
                         $sampled(i_valid), $sampled(i_aligner_tag));
        end

        a_err_count: assert property (@(posedge i_clock) disable iff (i_reset)
                o_valid |=> (o_sh_err_count == exp_err_count))
        else
        begin
                mismatches++;
                $display("mismatch at %0t: o_sh_err_count got %0d expected %0d", $time,
                         $sampled(o_sh_err_count), $sampled(exp_err_count));
        end

        a_lock_state: assert property (@(posedge i_clock) disable iff (i_reset)
                o_block_lock == exp_lock)
        else
        begin
                mismatches++;
                $display("mismatch at %0t: o_block_lock got %b expected %b", $time,
                         $sampled(o_block_lock), $sampled(exp_lock));
        end

        initial
        begin
                cycle_count = 0;
                while (cycle_count < TIMEOUT)
                begin
                        @(posedge i_clock);
                        cycle_count++;
                end
                $display("timeout: run did not finish within %0d cycles", TIMEOUT);
                $display("sim failed");
                $finish;
        end

        initial
        begin
                rng               = 32'h7615;
                mismatches        = 0;
                other_errors      = 0;
                i_reset           = 1'b1;
                i_valid           = 1'b0;
                i_data            = '0;
                i_aligner_tag     = 1'b0;
                i_rf_mode         = MODE_ALL;
                i_rf_update       = 1'b0;
                i_rf_error_burst  = '0;
                i_rf_error_period = '0;
                i_rf_error_repeat = '0;
                repeat (3) @(posedge i_clock);
                i_reset <= 1'b0;

                send_valid(64);                         // Clean stream until lock
                load_config(MODE_ALL, 16, 64, 1);       // Burst lands inside one lock window
                send_valid(63);
                send_valid(70);
                assert (lock_rises == 2 && lock_drops == 1)
                else
                begin
                        other_errors++;
                        $display("lock did not rise, drop and rise again, saw %0d rises %0d drops",
                                 lock_rises, lock_drops);
                end

                count_before = int'(o_sh_err_count);
                load_config(MODE_ALL, 3, 8, 4);
                send_valid(40);
                assert (int'(o_sh_err_count) - count_before == 12)
                else
                begin
                        mismatches++;
                        $display("mismatch at %0t: o_sh_err_count rose by %0d expected 12", $time,
                                 int'(o_sh_err_count) - count_before);
                end

                // Next strobe arrives while an all-block burst is still armed
                load_config(MODE_ALL, 2, 8, 1);
                drive_cycle(1'b0, 1'b0);
                load_config(MODE_CTRL, 2, 6, 3);
                send_valid(40);
                load_config(MODE_DATA, 4, 10, 2);
                send_valid(40);
                load_config(MODE_ALIGN, 2, 16, 3);
                send_valid(60);
                drive_cycle(1'b0, 1'b0);
                drive_cycle(1'b0, 1'b0);

                $display("checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
                if (mismatches == 0 && other_errors == 0)
                        $display("sim passed");
                else
                        $display("sim failed");
                $finish;
        end

endmodule

`default_nettype wire
